//--- hdl/lsu_cfg.svh
// load/store unit configuration
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// data bus
`define LSU_XLEN 64

// one strobe bit per data byte
`define LSU_STRB_W 8

// byte address
`define LSU_ADDR_W 32

// data RAM depth in 64-bit words, a power of two
`define LSU_RAM_WORDS 256

// cycles from request transfer to response valid, at least 1
`define LSU_RAM_LATENCY 2

`endif

//--- hdl/lsu_pkg.sv
// load/store unit types
`default_nettype none
`include "lsu_cfg.svh"

package lsu_pkg;

  typedef logic [`LSU_XLEN-1:0] lsu_word_t;
  typedef logic [`LSU_ADDR_W-1:0] lsu_addr_t;

  typedef enum logic {
    MEM_LOAD  = 1'b0,
    MEM_STORE = 1'b1
  } mem_op_e;

  // access size, log2 of the byte count
  typedef enum logic [1:0] {
    SZ_B = 2'd0,
    SZ_H = 2'd1,
    SZ_W = 2'd2,
    SZ_D = 2'd3
  } mem_size_e;

  // one access from the pipeline
  typedef struct packed {
    mem_op_e   op;
    mem_size_e size;
    logic      unsigned_ld; // zero extend on load
    lsu_addr_t addr;
    lsu_word_t wdata;       // store data, low bytes
  } mem_req_t;

  // write request channel, addr is 8-byte aligned
  typedef struct packed {
    lsu_addr_t                addr;
    lsu_word_t                data;
    logic [`LSU_STRB_W-1:0]   strb;
  } wr_req_t;

  // read request channel, addr is 8-byte aligned
  typedef struct packed {
    lsu_addr_t addr;
  } rd_req_t;

endpackage

`default_nettype wire

//--- hdl/lsu_store_align.sv
// store lane alignment
`timescale 1ns/10ps
`default_nettype none
`include "lsu_cfg.svh"

module lsu_store_align
  import lsu_pkg::*;
(
  input  wire mem_req_t             req_i,
  output lsu_word_t                 wr_data_o,
  output logic [`LSU_STRB_W-1:0]    wr_strb_o,
  output logic                      misaligned_o
);

  logic [2:0]              offset;
  logic [`LSU_STRB_W-1:0]  size_strb;

  assign offset = req_i.addr[2:0];

  // strobe of the access at lane 0, and its alignment rule
  always_comb begin
    unique case (req_i.size)
      SZ_B: begin
        size_strb    = 8'h01;
        misaligned_o = 1'b0;
      end
      SZ_H: begin
        size_strb    = 8'h03;
        misaligned_o = offset[0];
      end
      SZ_W: begin
        size_strb    = 8'h0f;
        misaligned_o = |offset[1:0];
      end
      default: begin
        size_strb    = 8'hff;
        misaligned_o = |offset;
      end
    endcase
  end

  // move data and strobes up to the addressed byte lane
  assign wr_data_o = req_i.wdata << {offset, 3'b000};
  assign wr_strb_o = size_strb << offset;

endmodule

`default_nettype wire

//--- hdl/lsu_load_extend.sv
// load byte extraction and extension
`timescale 1ns/10ps
`default_nettype none
`include "lsu_cfg.svh"

module lsu_load_extend
  import lsu_pkg::*;
(
  input  wire lsu_word_t  rd_data_i,
  input  wire [2:0]       offset_i,
  input  wire mem_size_e  size_i,
  input  wire             unsigned_i,
  output lsu_word_t       value_o
);

  lsu_word_t shifted;
  logic      top_bit;
  logic      fill;

  assign shifted = rd_data_i >> {offset_i, 3'b000}; // addressed byte to lane 0

  always_comb begin
    unique case (size_i)
      SZ_B:    top_bit = shifted[7];
      SZ_H:    top_bit = shifted[15];
      SZ_W:    top_bit = shifted[31];
      default: top_bit = shifted[`LSU_XLEN-1];
    endcase
  end

  assign fill = top_bit & ~unsigned_i;

  always_comb begin
    unique case (size_i)
      SZ_B:    value_o = {{(`LSU_XLEN-8){fill}}, shifted[7:0]};
      SZ_H:    value_o = {{(`LSU_XLEN-16){fill}}, shifted[15:0]};
      SZ_W:    value_o = {{(`LSU_XLEN-32){fill}}, shifted[31:0]};
      default: value_o = shifted; // full doubleword, nothing to extend
    endcase
  end

endmodule

`default_nettype wire

//--- hdl/lsu_mem_stage.sv
// memory stage bus sequencer
`timescale 1ns/10ps
`default_nettype none
`include "lsu_cfg.svh"

module lsu_mem_stage
  import lsu_pkg::*;
(
  input  wire             clk,
  input  wire             rst_n_i,
  // pipeline
  input  wire             req_valid_i,
  input  wire mem_req_t   req_i,
  output logic            busy_o,
  output logic            done_o,
  output logic            err_o,
  output lsu_word_t       rdata_o,
  // write request / response
  output logic            wr_valid_o,
  input  wire             wr_ready_i,
  output wr_req_t         wr_req_o,
  input  wire             wr_resp_valid_i,
  output logic            wr_resp_ready_o,
  // read request / data
  output logic            rd_valid_o,
  input  wire             rd_ready_i,
  output rd_req_t         rd_req_o,
  input  wire             rd_data_valid_i,
  output logic            rd_data_ready_o,
  input  wire lsu_word_t  rd_data_i
);

  typedef enum logic [2:0] {IDLE, WR_REQ, WR_RESP, RD_REQ, RD_DATA, FINISH} state_e;

  state_e                  state_q;
  logic                    req_fire;
  logic                    err_q;
  logic                    misaligned;
  lsu_word_t               st_data;
  logic [`LSU_STRB_W-1:0]  st_strb;
  wr_req_t                 bus_q;      // word address and store lanes
  mem_size_e               size_q;
  logic                    unsigned_q;
  logic [2:0]              offset_q;
  lsu_word_t               ld_value;
  lsu_word_t               rdata_q;

  lsu_store_align u_store_align (
    .req_i        (req_i),
    .wr_data_o    (st_data),
    .wr_strb_o    (st_strb),
    .misaligned_o (misaligned)
  );

  lsu_load_extend u_load_extend (
    .rd_data_i  (rd_data_i),
    .offset_i   (offset_q),
    .size_i     (size_q),
    .unsigned_i (unsigned_q),
    .value_o    (ld_value)
  );

  assign busy_o          = state_q inside {WR_REQ, WR_RESP, RD_REQ, RD_DATA};
  assign done_o          = (state_q == FINISH);
  assign err_o           = err_q;
  assign req_fire        = req_valid_i && !busy_o; // FINISH accepts too
  assign wr_valid_o      = (state_q == WR_REQ);
  assign wr_resp_ready_o = (state_q == WR_RESP);
  assign rd_valid_o      = (state_q == RD_REQ);
  assign rd_data_ready_o = (state_q == RD_DATA);
  assign wr_req_o        = bus_q;
  assign rd_req_o        = '{addr: bus_q.addr};
  assign rdata_o         = rdata_q;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
      err_q   <= 1'b0;
    end else begin
      err_q <= req_fire && misaligned; // misaligned goes straight to FINISH
      unique case (state_q)
        IDLE, FINISH: begin
          if (!req_fire) begin
            state_q <= IDLE;
          end else if (misaligned) begin
            state_q <= FINISH;
          end else if (req_i.op == MEM_STORE) begin
            state_q <= WR_REQ;
          end else begin
            state_q <= RD_REQ;
          end
        end
        WR_REQ:  if (wr_ready_i) state_q <= WR_RESP;
        WR_RESP: if (wr_resp_valid_i) state_q <= FINISH;
        RD_REQ:  if (rd_ready_i) state_q <= RD_DATA;
        RD_DATA: if (rd_data_valid_i) state_q <= FINISH;
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (req_fire) begin
      bus_q.addr <= {req_i.addr[`LSU_ADDR_W-1:3], 3'b000};
      bus_q.data <= st_data;
      bus_q.strb <= st_strb;
      size_q     <= req_i.size;
      unsigned_q <= req_i.unsigned_ld;
      offset_q   <= req_i.addr[2:0];
    end
    if (rd_data_valid_i && rd_data_ready_o) begin
      rdata_q <= ld_value;
    end
  end

  // pipeline must honour the stall
  a_no_req_while_busy: assert property (@(posedge clk) disable iff (!rst_n_i)
    busy_o |-> !req_valid_i);

endmodule

`default_nettype wire

//--- hdl/lsu_data_ram.sv
// byte-masked data RAM bus slave
`timescale 1ns/10ps
`default_nettype none
`include "lsu_cfg.svh"

module lsu_data_ram
  import lsu_pkg::*;
(
  input  wire             clk,
  input  wire             rst_n_i,
  // write request / response
  input  wire             wr_valid_i,
  output logic            wr_ready_o,
  input  wire wr_req_t    wr_req_i,
  output logic            wr_resp_valid_o,
  input  wire             wr_resp_ready_i,
  // read request / data
  input  wire             rd_valid_i,
  output logic            rd_ready_o,
  input  wire rd_req_t    rd_req_i,
  output logic            rd_data_valid_o,
  input  wire             rd_data_ready_i,
  output lsu_word_t       rd_data_o
);

  localparam int IDX_W = $clog2(`LSU_RAM_WORDS);
  localparam int CNT_W = $clog2(`LSU_RAM_LATENCY + 1);

  typedef enum logic [2:0] {IDLE, WR_WAIT, WR_RESP, RD_WAIT, RD_RESP} state_e;

  state_e            state_q;
  logic [CNT_W-1:0]  cnt_q;
  logic              wr_fire;
  logic              rd_fire;
  logic [IDX_W-1:0]  wr_idx;
  logic [IDX_W-1:0]  rd_idx;
  lsu_word_t         mem [`LSU_RAM_WORDS];
  lsu_word_t         rd_data_q;

  assign rd_ready_o      = (state_q == IDLE);
  assign wr_ready_o      = (state_q == IDLE) && !rd_valid_i; // read wins a tie
  assign rd_fire         = rd_valid_i && rd_ready_o;
  assign wr_fire         = wr_valid_i && wr_ready_o;
  assign wr_resp_valid_o = (state_q == WR_RESP);
  assign rd_data_valid_o = (state_q == RD_RESP);
  assign rd_data_o       = rd_data_q;

  // word index wraps at the RAM depth
  assign wr_idx = wr_req_i.addr[3 +: IDX_W];
  assign rd_idx = rd_req_i.addr[3 +: IDX_W];

  // latency counter, response valid LSU_RAM_LATENCY cycles after transfer
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else begin
      unique case (state_q)
        IDLE: begin
          cnt_q <= CNT_W'(`LSU_RAM_LATENCY - 1);
          if (rd_fire) begin
            state_q <= (`LSU_RAM_LATENCY == 1) ? RD_RESP : RD_WAIT;
          end else if (wr_fire) begin
            state_q <= (`LSU_RAM_LATENCY == 1) ? WR_RESP : WR_WAIT;
          end
        end
        WR_WAIT, RD_WAIT: begin
          cnt_q <= cnt_q - 1'b1;
          if (cnt_q == CNT_W'(1)) begin
            state_q <= (state_q == WR_WAIT) ? WR_RESP : RD_RESP;
          end
        end
        WR_RESP: if (wr_resp_ready_i) state_q <= IDLE;
        RD_RESP: if (rd_data_ready_i) state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  // array access happens on the request transfer
  always_ff @(posedge clk) begin
    if (wr_fire) begin
      for (int b = 0; b < `LSU_STRB_W; b++) begin
        if (wr_req_i.strb[b]) begin
          mem[wr_idx][b*8 +: 8] <= wr_req_i.data[b*8 +: 8];
        end
      end
    end
    if (rd_fire) begin
      rd_data_q <= mem[rd_idx]; // held until the read data transfer
    end
  end

  // master must present whole-word addresses
  a_wr_aligned: assert property (@(posedge clk) disable iff (!rst_n_i)
    wr_valid_i |-> wr_req_i.addr[2:0] == 3'b000);

  a_rd_aligned: assert property (@(posedge clk) disable iff (!rst_n_i)
    rd_valid_i |-> rd_req_i.addr[2:0] == 3'b000);

endmodule

`default_nettype wire

//--- hdl/lsu_top.sv
// load/store unit top level
`timescale 1ns/10ps
`default_nettype none

module lsu_top
  import lsu_pkg::*;
(
  input  wire             clk,
  input  wire             rst_n_i,
  input  wire             req_valid_i,
  input  wire mem_req_t   req_i,
  output logic            busy_o,
  output logic            done_o,
  output logic            err_o,
  output lsu_word_t       rdata_o
);

  // bus between stage and RAM
  logic       wr_valid;
  logic       wr_ready;
  wr_req_t    wr_req;
  logic       wr_resp_valid;
  logic       wr_resp_ready;
  logic       rd_valid;
  logic       rd_ready;
  rd_req_t    rd_req;
  logic       rd_data_valid;
  logic       rd_data_ready;
  lsu_word_t  rd_data;

  lsu_mem_stage u_mem_stage (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .req_valid_i     (req_valid_i),
    .req_i           (req_i),
    .busy_o          (busy_o),
    .done_o          (done_o),
    .err_o           (err_o),
    .rdata_o         (rdata_o),
    .wr_valid_o      (wr_valid),
    .wr_ready_i      (wr_ready),
    .wr_req_o        (wr_req),
    .wr_resp_valid_i (wr_resp_valid),
    .wr_resp_ready_o (wr_resp_ready),
    .rd_valid_o      (rd_valid),
    .rd_ready_i      (rd_ready),
    .rd_req_o        (rd_req),
    .rd_data_valid_i (rd_data_valid),
    .rd_data_ready_o (rd_data_ready),
    .rd_data_i       (rd_data)
  );

  lsu_data_ram u_data_ram (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .wr_valid_i      (wr_valid),
    .wr_ready_o      (wr_ready),
    .wr_req_i        (wr_req),
    .wr_resp_valid_o (wr_resp_valid),
    .wr_resp_ready_i (wr_resp_ready),
    .rd_valid_i      (rd_valid),
    .rd_ready_o      (rd_ready),
    .rd_req_i        (rd_req),
    .rd_data_valid_o (rd_data_valid),
    .rd_data_ready_i (rd_data_ready),
    .rd_data_o       (rd_data)
  );

endmodule

`default_nettype wire

//--- bench/lsu_tb_table.svh
// access table for the testbench
`ifndef LSU_TB_TABLE_SVH
`define LSU_TB_TABLE_SVH

// columns: op, size, unsigned, address, store data, random data,
// expected rdata_o, expected err_o
task automatic fill_table();
  // doubleword round trip
  add_row(MEM_STORE, SZ_D, 1'b0, 32'h0000_0100, 64'h0123_4567_89ab_cdef, 1'b0, 64'h0, 1'b0);
  add_row(MEM_LOAD,  SZ_D, 1'b0, 32'h0000_0100, 64'h0, 1'b0, 64'h0123_4567_89ab_cdef, 1'b0);
  // byte and half lanes merged into one word
  add_row(MEM_STORE, SZ_D, 1'b0, 32'h0000_0108, 64'h8877_6655_4433_2211, 1'b0, 64'h0, 1'b0);
  add_row(MEM_STORE, SZ_B, 1'b0, 32'h0000_0108, 64'h0000_0000_0000_00aa, 1'b0, 64'h0, 1'b0);
  add_row(MEM_STORE, SZ_B, 1'b0, 32'h0000_010b, 64'h0000_0000_0000_00bb, 1'b0, 64'h0, 1'b0);
  add_row(MEM_STORE, SZ_H, 1'b0, 32'h0000_010c, 64'h0000_0000_0000_ccdd, 1'b0, 64'h0, 1'b0);
  add_row(MEM_LOAD,  SZ_D, 1'b0, 32'h0000_0108, 64'h0, 1'b0, 64'h8877_ccdd_bb33_22aa, 1'b0);
  // upper store data bits outside the size must not land
  add_row(MEM_STORE, SZ_D, 1'b0, 32'h0000_0110, 64'h0000_0000_0000_0000, 1'b0, 64'h0, 1'b0);
  add_row(MEM_STORE, SZ_W, 1'b0, 32'h0000_0114, 64'h0000_0000_cafe_f00d, 1'b0, 64'h0, 1'b0);
  add_row(MEM_STORE, SZ_H, 1'b0, 32'h0000_0112, 64'h0000_0000_0000_9abc, 1'b0, 64'h0, 1'b0);
  add_row(MEM_STORE, SZ_B, 1'b0, 32'h0000_0111, 64'hdead_beef_0000_007e, 1'b0, 64'h0, 1'b0);
  add_row(MEM_LOAD,  SZ_D, 1'b0, 32'h0000_0110, 64'h0, 1'b0, 64'hcafe_f00d_9abc_7e00, 1'b0);
  // sign and zero extension, top bit set and clear
  add_row(MEM_STORE, SZ_D, 1'b0, 32'h0000_0118, 64'h98ba_dcfe_1234_807f, 1'b0, 64'h0, 1'b0);
  add_row(MEM_LOAD,  SZ_B, 1'b0, 32'h0000_0118, 64'h0, 1'b0, 64'h0000_0000_0000_007f, 1'b0);
  add_row(MEM_LOAD,  SZ_B, 1'b0, 32'h0000_0119, 64'h0, 1'b0, 64'hffff_ffff_ffff_ff80, 1'b0);
  add_row(MEM_LOAD,  SZ_B, 1'b1, 32'h0000_0119, 64'h0, 1'b0, 64'h0000_0000_0000_0080, 1'b0);
  add_row(MEM_LOAD,  SZ_H, 1'b0, 32'h0000_0118, 64'h0, 1'b0, 64'hffff_ffff_ffff_807f, 1'b0);
  add_row(MEM_LOAD,  SZ_H, 1'b1, 32'h0000_0118, 64'h0, 1'b0, 64'h0000_0000_0000_807f, 1'b0);
  add_row(MEM_LOAD,  SZ_H, 1'b0, 32'h0000_011a, 64'h0, 1'b0, 64'h0000_0000_0000_1234, 1'b0);
  add_row(MEM_LOAD,  SZ_W, 1'b0, 32'h0000_0118, 64'h0, 1'b0, 64'h0000_0000_1234_807f, 1'b0);
  add_row(MEM_LOAD,  SZ_W, 1'b0, 32'h0000_011c, 64'h0, 1'b0, 64'hffff_ffff_98ba_dcfe, 1'b0);
  add_row(MEM_LOAD,  SZ_W, 1'b1, 32'h0000_011c, 64'h0, 1'b0, 64'h0000_0000_98ba_dcfe, 1'b0);
  add_row(MEM_LOAD,  SZ_D, 1'b0, 32'h0000_0118, 64'h0, 1'b0, 64'h98ba_dcfe_1234_807f, 1'b0);
  // misaligned, memory untouched afterwards
  add_row(MEM_STORE, SZ_H, 1'b0, 32'h0000_0101, 64'h0000_0000_0000_ffff, 1'b0, 64'h0, 1'b1);
  add_row(MEM_STORE, SZ_W, 1'b0, 32'h0000_0102, 64'h0000_0000_ffff_ffff, 1'b0, 64'h0, 1'b1);
  add_row(MEM_STORE, SZ_D, 1'b0, 32'h0000_0104, 64'hffff_ffff_ffff_ffff, 1'b0, 64'h0, 1'b1);
  add_row(MEM_LOAD,  SZ_D, 1'b0, 32'h0000_0100, 64'h0, 1'b0, 64'h0123_4567_89ab_cdef, 1'b0);
  add_row(MEM_LOAD,  SZ_W, 1'b0, 32'h0000_011a, 64'h0, 1'b0, 64'h0, 1'b1);
  add_row(MEM_LOAD,  SZ_H, 1'b0, 32'h0000_011b, 64'h0, 1'b0, 64'h0, 1'b1);
  // region for the random accesses, random fill
  add_row(MEM_STORE, SZ_D, 1'b0, 32'h0000_0200, 64'h0, 1'b1, 64'h0, 1'b0);
  add_row(MEM_STORE, SZ_D, 1'b0, 32'h0000_0208, 64'h0, 1'b1, 64'h0, 1'b0);
  add_row(MEM_STORE, SZ_D, 1'b0, 32'h0000_0210, 64'h0, 1'b1, 64'h0, 1'b0);
  add_row(MEM_STORE, SZ_D, 1'b0, 32'h0000_0218, 64'h0, 1'b1, 64'h0, 1'b0);
  add_row(MEM_STORE, SZ_D, 1'b0, 32'h0000_0220, 64'h0, 1'b1, 64'h0, 1'b0);
  add_row(MEM_STORE, SZ_D, 1'b0, 32'h0000_0228, 64'h0, 1'b1, 64'h0, 1'b0);
  add_row(MEM_STORE, SZ_D, 1'b0, 32'h0000_0230, 64'h0, 1'b1, 64'h0, 1'b0);
  add_row(MEM_STORE, SZ_D, 1'b0, 32'h0000_0238, 64'h0, 1'b1, 64'h0, 1'b0);
endtask

`endif

//--- bench/lsu_tb.sv
// load/store unit testbench
`timescale 1ns/10ps
`default_nettype none
`include "lsu_cfg.svh"

module lsu_tb
  import lsu_pkg::*;
();

  localparam int MAX_ROWS    = 64;
  localparam int NUM_RANDOM  = 40;
  localparam int MODEL_BYTES = `LSU_RAM_WORDS * 8;
  localparam int RAND_BASE   = 32'h200;

  typedef struct packed {
    mem_op_e   op;
    mem_size_e size;
    logic      uns;
    lsu_addr_t addr;
    lsu_word_t wdata;
    logic      rnd;       // store data from the LFSR
    lsu_word_t exp_rdata;
    logic      exp_err;
  } row_t;

  logic       clk = 1'b0;
  logic       rst_n_i;
  logic       req_valid_i;
  mem_req_t   req_i;
  logic       busy_o;
  logic       done_o;
  logic       err_o;
  lsu_word_t  rdata_o;

  row_t        rows [MAX_ROWS];
  int          n_rows;
  logic [31:0] lfsr_q;
  logic [7:0]  ref_mem [MODEL_BYTES]; // byte image of the data RAM

  lsu_top UUT (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .busy_o      (busy_o),
    .done_o      (done_o),
    .err_o       (err_o),
    .rdata_o     (rdata_o)
  );

  always #50 clk = ~clk;

  task automatic add_row(input mem_op_e op, input mem_size_e size, input logic uns,
                         input lsu_addr_t addr, input lsu_word_t wdata, input logic rnd,
                         input lsu_word_t exp_rdata, input logic exp_err);
    rows[n_rows] = '{op, size, uns, addr, wdata, rnd, exp_rdata, exp_err};
    n_rows++;
  endtask

  `include "lsu_tb_table.svh"

  // feedback polynomial x^32 + x^22 + x^2 + x + 1
  function automatic lsu_word_t rand_bits(input int n);
    lsu_word_t v;
    logic      fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      v      = {v[62:0], fb};
    end
    return v;
  endfunction

  function automatic int byte_count(input mem_size_e size);
    return 1 << int'(size);
  endfunction

  task automatic model_store(input lsu_addr_t addr, input mem_size_e size, input lsu_word_t d);
    for (int i = 0; i < byte_count(size); i++) begin
      ref_mem[(addr + i) % MODEL_BYTES] = d[8*i +: 8];
    end
  endtask

  function automatic lsu_word_t model_load(input lsu_addr_t addr, input mem_size_e size,
                                           input logic uns);
    lsu_word_t v;
    int        n;
    logic      fill;
    v = '0;
    n = byte_count(size);
    for (int i = 0; i < n; i++) begin
      v[8*i +: 8] = ref_mem[(addr + i) % MODEL_BYTES];
    end
    fill = !uns && v[8*n-1];
    for (int i = n; i < 8; i++) begin
      v[8*i +: 8] = {8{fill}};
    end
    return v;
  endfunction

  task automatic abort_run();
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input lsu_word_t got, input lsu_word_t exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_err(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
      abort_run();
    end
  endtask

  // one strobe and then busy_o watched until done_o
  task automatic run_access(input mem_req_t req, output lsu_word_t rdata, output logic err);
    @(posedge clk);
    req_valid_i <= 1'b1;
    req_i       <= req;
    @(negedge clk);
    if (done_o !== 1'b0) begin
      $display("done_o stayed high for more than one cycle before address %h", req.addr);
      abort_run();
    end
    @(posedge clk); // accepted on this edge
    req_valid_i <= 1'b0;
    @(negedge clk);
    if (busy_o !== 1'b1 && done_o !== 1'b1) begin
      $display("Request at address %h was not accepted", req.addr);
      abort_run();
    end
    while (done_o !== 1'b1) begin
      @(negedge clk);
      if (done_o !== 1'b1 && busy_o !== 1'b1) begin
        $display("busy_o fell before done_o at address %h", req.addr);
        abort_run();
      end
    end
    if (busy_o !== 1'b0) begin
      $display("busy_o still high together with done_o at address %h", req.addr);
      abort_run();
    end
    rdata = rdata_o;
    err   = err_o;
  endtask

  task automatic apply_and_check(input mem_req_t req, input lsu_word_t exp_rdata,
                                 input logic exp_err);
    lsu_word_t rdata;
    logic      err;
    run_access(req, rdata, err);
    check_err("err_o", err, exp_err);
    if (req.op == MEM_LOAD && !exp_err) begin
      check_word("rdata_o", rdata, exp_rdata);
    end
    if (req.op == MEM_STORE && !exp_err) begin
      model_store(req.addr, req.size, req.wdata);
    end
  endtask

  initial begin
    mem_req_t  req;
    lsu_word_t exp;
    int        off;
    int        word;
    rst_n_i     = 1'b0;
    req_valid_i = 1'b0;
    req_i       = '0;
    lfsr_q      = 32'hafc4;
    n_rows      = 0;
    fill_table();
    repeat (5) @(posedge clk);
    rst_n_i <= 1'b1;
    @(negedge clk);
    if (busy_o !== 1'b0 || done_o !== 1'b0 || err_o !== 1'b0) begin
      $display("Status outputs are not low after reset");
      abort_run();
    end

    for (int i = 0; i < n_rows; i++) begin
      req.op          = rows[i].op;
      req.size        = rows[i].size;
      req.unsigned_ld = rows[i].uns;
      req.addr        = rows[i].addr;
      req.wdata       = rows[i].rnd ? rand_bits(64) : rows[i].wdata;
      apply_and_check(req, rows[i].exp_rdata, rows[i].exp_err);
    end

    // mixed accesses inside the filled region aligned to their size
    for (int i = 0; i < NUM_RANDOM; i++) begin
      req.op          = mem_op_e'(1'(rand_bits(1)));
      req.size        = mem_size_e'(2'(rand_bits(2)));
      req.unsigned_ld = (rand_bits(1) != 0);
      word            = int'(rand_bits(3));
      off             = int'(rand_bits(3));
      off             = off - off % byte_count(req.size);
      req.addr        = lsu_addr_t'(RAND_BASE + word * 8 + off);
      req.wdata       = rand_bits(64);
      exp = (req.op == MEM_LOAD) ? model_load(req.addr, req.size, req.unsigned_ld) : '0;
      apply_and_check(req, exp, 1'b0);
    end

    $display("All checks passed");
    $finish;
  end

  // watchdog sized from the number of accesses
  initial begin
    @(posedge rst_n_i);
    repeat ((n_rows + NUM_RANDOM) * (`LSU_RAM_LATENCY + 10)) @(posedge clk);
    $display("Timeout, the unit never finished an access");
    abort_run();
  end

endmodule

`default_nettype wire

//--- lsu_top.f
+incdir+hdl
+incdir+bench
hdl/lsu_pkg.sv
hdl/lsu_store_align.sv
hdl/lsu_load_extend.sv
hdl/lsu_mem_stage.sv
hdl/lsu_data_ram.sv
hdl/lsu_top.sv
bench/lsu_tb.sv

//--- Bender.yml
package:
  name: lsu

export_include_dirs:
  - hdl

sources:
  - files:
      - hdl/lsu_pkg.sv
      - hdl/lsu_store_align.sv
      - hdl/lsu_load_extend.sv
      - hdl/lsu_mem_stage.sv
      - hdl/lsu_data_ram.sv
      - hdl/lsu_top.sv
  - target: simulation
    include_dirs:
      - bench
    files:
      - bench/lsu_tb.sv
